/* verilog/mult18_pkg.sv */
`default_nettype none

package mult18_pkg;

  localparam int pp_w      = 20;
  localparam int pp_count  = 9;
  localparam int pp_last_w = 18;
  localparam int product_w = 36;

  // width of one compressed group of three rows after stage 1
  localparam int grp_w     = 24;
  // pair a sits at column 0 of the product and pair b at column 7
  localparam int pair_a_w  = 30;
  localparam int pair_b_w  = 29;

  typedef logic [pp_w-1:0]      pp_t;
  typedef logic [pp_last_w-1:0] pp_last_t;
  typedef logic [product_w-1:0] product_t;

  // pp[k] carries partial product k+1 with weight 4**k
  typedef struct packed {
    pp_t [pp_count-1:0] pp;
    pp_last_t           pp_last;
  } pp_set_t;

  // carry vectors are kept unshifted, carry bit i has weight 2**(i+1)
  typedef struct packed {
    logic [pair_a_w-1:0] sum_a;
    logic [pair_a_w-1:0] carry_a;
    logic [pair_b_w-1:0] sum_b;
    logic [pair_b_w-1:0] carry_b;
    pp_last_t            pp_last;
  } upper_cs_t;

  typedef struct packed {
    product_t sum;
    product_t carry;
    pp_last_t pp_last;
  } mid_cs_t;

endpackage

`default_nettype wire

/* verilog/mult18_pipe_pkg.sv */
`default_nettype none

package mult18_pipe_pkg;

  // register point on the incoming partial products
  localparam bit pipe_in    = 1'b1;

  // register point after reduction stage 2
  localparam bit pipe_upper = 1'b1;

  // register point after reduction stage 4
  localparam bit pipe_mid   = 1'b1;

  // register point after the carry-propagate adder
  localparam bit pipe_out   = 1'b1;

  // cycles from a sampled operand set to its product on the output
  localparam int latency = int'(pipe_in) + int'(pipe_upper) +
                           int'(pipe_mid) + int'(pipe_out);

endpackage

`default_nettype wire

/* verilog/csa_row.sv */
`default_nettype none

module csa_row #(
  parameter int width = 24
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  logic [width-1:0] c,
  output logic [width-1:0] sum,
  output logic [width-1:0] carry
);

  // one 3:2 counter per column with no ripple between columns
  // a column with a zero input behaves as a half adder
  assign sum = a ^ b ^ c;

  // carry[i] belongs to column i+1, the caller shifts it into place
  assign carry = (a & b) | (a & c) | (b & c);

endmodule

`default_nettype wire

/* verilog/stage_reg.sv */
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic,
  parameter bit  enable    = 1'b1
) (
  input  logic     clk,
  input  logic     rstn,
  input  payload_t d,
  output payload_t q
);

  generate
    if (enable) begin : g_reg
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          q <= '0;
        end else begin
          q <= d;
        end
      end
    end else begin : g_bypass
      assign q = d;
    end
  endgenerate

endmodule

`default_nettype wire

/* verilog/wtree_reduce_upper.sv */
`default_nettype none

module wtree_reduce_upper (
  input  mult18_pkg::pp_set_t   pp,
  output mult18_pkg::upper_cs_t cs
);

  localparam int grp_w = mult18_pkg::grp_w;

  logic [grp_w-1:0] row_a   [3];
  logic [grp_w-1:0] row_b   [3];
  logic [grp_w-1:0] row_c   [3];
  logic [grp_w-1:0] g_sum   [3];
  logic [grp_w-1:0] g_carry [3];

  logic [mult18_pkg::pair_a_w-1:0] sum_a;
  logic [mult18_pkg::pair_a_w-1:0] carry_a;
  logic [mult18_pkg::pair_b_w-1:0] sum_b;
  logic [mult18_pkg::pair_b_w-1:0] carry_b;

  // stage 1 compresses rows 3g, 3g+1, 3g+2 at shifts 0, 2 and 4
  // column 23 sees only sign bits, so each pair extends by repeating bit 23
  for (genvar g = 0; g < 3; g++) begin : g_stage1
    assign row_a[g] = {{4{pp.pp[3*g][19]}}, pp.pp[3*g]};
    assign row_b[g] = {{2{pp.pp[3*g+1][19]}}, pp.pp[3*g+1], 2'b00};
    assign row_c[g] = {pp.pp[3*g+2], 4'b0000};

    csa_row #(
      .width(grp_w)
    ) u_csa (
      .a    (row_a[g]),
      .b    (row_b[g]),
      .c    (row_c[g]),
      .sum  (g_sum[g]),
      .carry(g_carry[g])
    );
  end

  // pair a adds the group 2 sum at column 6 to the group 1 pair
  csa_row #(
    .width(mult18_pkg::pair_a_w)
  ) u_stage2_a (
    .a    ({{6{g_sum[0][23]}}, g_sum[0]}),
    .b    ({{5{g_carry[0][23]}}, g_carry[0], 1'b0}),
    .c    ({g_sum[1], 6'b0}),
    .sum  (sum_a),
    .carry(carry_a)
  );

  // pair b is based at column 7, where group 2 carries start
  // group 3 sum lands at offset 5 and its carries at offset 6
  // the top carry of group 3 falls above bit 35 and is not needed
  csa_row #(
    .width(mult18_pkg::pair_b_w)
  ) u_stage2_b (
    .a    ({{5{g_carry[1][23]}}, g_carry[1]}),
    .b    ({g_sum[2], 5'b0}),
    .c    ({g_carry[2][22:0], 6'b0}),
    .sum  (sum_b),
    .carry(carry_b)
  );

  assign cs = '{
    sum_a:   sum_a,
    carry_a: carry_a,
    sum_b:   sum_b,
    carry_b: carry_b,
    pp_last: pp.pp_last
  };

endmodule

`default_nettype wire

/* verilog/wtree_reduce_mid.sv */
`default_nettype none

module wtree_reduce_mid (
  input  mult18_pkg::upper_cs_t cs_in,
  output mult18_pkg::mid_cs_t   cs_out
);

  mult18_pkg::product_t s3;
  mult18_pkg::product_t c3;
  mult18_pkg::product_t s4;
  mult18_pkg::product_t c4;

  // stage 3 widens pair a to the full product width
  // its top column holds only sign bits, so bit 29 is repeated upwards
  // pair b sum enters at column 7, its base column
  csa_row #(
    .width(mult18_pkg::product_w)
  ) u_stage3 (
    .a    ({{6{cs_in.sum_a[29]}}, cs_in.sum_a}),
    .b    ({{5{cs_in.carry_a[29]}}, cs_in.carry_a, 1'b0}),
    .c    ({cs_in.sum_b, 7'b0}),
    .sum  (s3),
    .carry(c3)
  );

  // stage 4 folds in the pair b carries, one column above the pair b base
  // anything that would land on bit 36 or higher is dropped
  csa_row #(
    .width(mult18_pkg::product_w)
  ) u_stage4 (
    .a    (s3),
    .b    ({c3[34:0], 1'b0}),
    .c    ({cs_in.carry_b[27:0], 8'b0}),
    .sum  (s4),
    .carry(c4)
  );

  assign cs_out = '{
    sum:     s4,
    carry:   c4,
    pp_last: cs_in.pp_last
  };

endmodule

`default_nettype wire

/* verilog/wtree_resolve.sv */
`default_nettype none

module wtree_resolve (
  input  mult18_pkg::mid_cs_t  cs,
  output mult18_pkg::product_t product
);

  mult18_pkg::product_t s5;
  mult18_pkg::product_t c5;

  // stage 5 adds the correction row at column 18
  // the row is unsigned and needs no extension
  csa_row #(
    .width(mult18_pkg::product_w)
  ) u_stage5 (
    .a    (cs.sum),
    .b    ({cs.carry[34:0], 1'b0}),
    .c    ({cs.pp_last, 18'b0}),
    .sum  (s5),
    .carry(c5)
  );

  // the carry-propagate adder wraps modulo 2**36
  assign product = s5 + {c5[34:0], 1'b0};

endmodule

`default_nettype wire

/* verilog/mult18_wtree.sv */
`default_nettype none

module mult18_wtree (
  input  logic                 clk,
  input  logic                 rstn,
  input  mult18_pkg::pp_set_t  pp_in,
  output mult18_pkg::product_t final_p
);

  mult18_pkg::pp_set_t   pp_q;
  mult18_pkg::upper_cs_t upper_d;
  mult18_pkg::upper_cs_t upper_q;
  mult18_pkg::mid_cs_t   mid_d;
  mult18_pkg::mid_cs_t   mid_q;
  mult18_pkg::product_t  product_d;

  // a new operand set is taken every cycle, there is no stall path
  stage_reg #(
    .payload_t(mult18_pkg::pp_set_t),
    .enable   (mult18_pipe_pkg::pipe_in)
  ) u_in (
    .clk (clk),
    .rstn(rstn),
    .d   (pp_in),
    .q   (pp_q)
  );

  wtree_reduce_upper u_reduce_upper (
    .pp(pp_q),
    .cs(upper_d)
  );

  stage_reg #(
    .payload_t(mult18_pkg::upper_cs_t),
    .enable   (mult18_pipe_pkg::pipe_upper)
  ) u_upper (
    .clk (clk),
    .rstn(rstn),
    .d   (upper_d),
    .q   (upper_q)
  );

  wtree_reduce_mid u_reduce_mid (
    .cs_in (upper_q),
    .cs_out(mid_d)
  );

  // the correction row rides in mid_cs_t so it stays with its own set
  stage_reg #(
    .payload_t(mult18_pkg::mid_cs_t),
    .enable   (mult18_pipe_pkg::pipe_mid)
  ) u_mid (
    .clk (clk),
    .rstn(rstn),
    .d   (mid_d),
    .q   (mid_q)
  );

  wtree_resolve u_resolve (
    .cs     (mid_q),
    .product(product_d)
  );

  stage_reg #(
    .payload_t(mult18_pkg::product_t),
    .enable   (mult18_pipe_pkg::pipe_out)
  ) u_out (
    .clk (clk),
    .rstn(rstn),
    .d   (product_d),
    .q   (final_p)
  );

endmodule

`default_nettype wire

/* test/tb_mult18_ref.svh */
`ifndef TB_MULT18_REF_SVH
`define TB_MULT18_REF_SVH

// partial product k+1 sits at column 2k, the correction row at column 18
function automatic mult18_pkg::product_t expected_product(input mult18_pkg::pp_set_t s);
  mult18_pkg::product_t acc;
  mult18_pkg::product_t row;
  acc = '0;
  for (int k = 0; k < mult18_pkg::pp_count; k++) begin
    row = {{16{s.pp[k][19]}}, s.pp[k]};
    acc = acc + (row << (2 * k));
  end
  // the correction row is unsigned
  row = {18'b0, s.pp_last};
  acc = acc + (row << 18);
  return acc;
endfunction

// digit k of the radix-4 Booth recoding of b looks at b[2k+1], b[2k] and b[2k-1]
function automatic mult18_pkg::pp_set_t booth_set(input logic signed [17:0] a,
                                                  input logic signed [17:0] b);
  mult18_pkg::pp_set_t s;
  logic [18:0]         bx;
  logic [2:0]          grp;
  logic signed [19:0]  a_ext;
  s = '0;
  bx = {b, 1'b0};
  a_ext = {{2{a[17]}}, a};
  for (int k = 0; k < mult18_pkg::pp_count; k++) begin
    grp = bx[2*k +: 3];
    case (grp)
      3'b001, 3'b010: s.pp[k] = a_ext;
      3'b011:         s.pp[k] = a_ext <<< 1;
      3'b100:         s.pp[k] = -(a_ext <<< 1);
      3'b101, 3'b110: s.pp[k] = -a_ext;
      default:        s.pp[k] = '0;
    endcase
  end
  return s;
endfunction

task automatic check_product(input mult18_pkg::product_t got,
                             input mult18_pkg::product_t exp,
                             input string what);
  if (got !== exp) begin
    mismatch_errors++;
    $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_reset(input mult18_pkg::product_t got, input string what);
  if (got !== '0) begin
    mismatch_errors++;
    $display("Mismatch at %0d ns: %s, got %h, expected 0", $time, what, got);
  end
endtask

`endif

/* test/tb_mult18_wtree.sv */
`default_nettype none

module tb_mult18_wtree;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period    = 100;
  localparam int n_zero        = 1;
  localparam int n_single      = 2 * mult18_pkg::pp_count + 1;
  localparam int n_booth_fixed = 6;
  localparam int n_booth_rand  = 40;
  localparam int n_raw         = 64;
  localparam int n_neg         = 12;
  localparam int total_vectors = n_zero + n_single + n_booth_fixed + n_booth_rand +
                                 n_raw + n_neg;
  localparam int watchdog_cycles = total_vectors + mult18_pipe_pkg::latency + 20;

  logic                 clk;
  logic                 rstn;
  mult18_pkg::pp_set_t  pp_in;
  mult18_pkg::product_t final_p;

  integer seed;
  int     mismatch_errors = 0;
  int     other_errors = 0;
  int     checked = 0;
  bit     stim_done;

  mult18_pkg::product_t exp_q[$];
  string                label_q[$];

  `include "tb_mult18_ref.svh"

  mult18_wtree uut (
    .clk    (clk),
    .rstn   (rstn),
    .pp_in  (pp_in),
    .final_p(final_p)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // drives one set at the current falling edge, then waits for the next one
  task automatic drive_set(input mult18_pkg::pp_set_t s,
                           input mult18_pkg::product_t exp,
                           input string label);
    pp_in = s;
    exp_q.push_back(exp);
    label_q.push_back(label);
    @(negedge clk);
  endtask

  function automatic mult18_pkg::pp_set_t random_set(input bit force_negative);
    mult18_pkg::pp_set_t s;
    logic [31:0]         r;
    for (int k = 0; k < mult18_pkg::pp_count; k++) begin
      r = $random(seed);
      s.pp[k] = r[19:0];
      if (force_negative) begin
        s.pp[k][19] = 1'b1;
      end
    end
    r = $random(seed);
    s.pp_last = r[17:0];
    return s;
  endfunction

  task automatic drive_booth(input logic signed [17:0] a, input logic signed [17:0] b);
    mult18_pkg::pp_set_t s;
    logic signed [35:0]  ab;
    s = booth_set(a, b);
    ab = a * b;
    // the Booth rows must add up to a times b before they go to the DUT
    check_product(expected_product(s), ab,
                  $sformatf("reference sum of Booth rows for %0d x %0d", a, b));
    drive_set(s, ab, $sformatf("Booth %0d x %0d", a, b));
  endtask

  initial begin : stimulus
    mult18_pkg::pp_set_t  s;
    mult18_pkg::product_t exp;
    logic [31:0]          r;
    logic [19:0]          v;
    seed = 32'h3830;
    pp_in = '0;
    rstn = 1'b0;
    stim_done = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_reset(final_p, "output during reset");
    end
    rstn = 1'b1;

    drive_set('0, '0, "all rows zero");

    // one row at a time exercises each column alignment
    for (int k = 0; k < mult18_pkg::pp_count; k++) begin
      for (int neg = 0; neg < 2; neg++) begin
        r = $random(seed);
        v = r[19:0];
        v[19] = neg[0];
        s = '0;
        s.pp[k] = v;
        exp = {{16{v[19]}}, v} << (2 * k);
        drive_set(s, exp, $sformatf("row %0d alone, value %h", k + 1, v));
      end
    end
    r = $random(seed);
    s = '0;
    s.pp_last = r[17:0];
    exp = mult18_pkg::product_t'(s.pp_last) << 18;
    drive_set(s, exp, "correction row alone");

    drive_booth(18'h20000, 18'h20000);
    drive_booth(18'h00000, 18'h2d0f5);
    drive_booth(18'h03039, 18'h00000);
    drive_booth(18'h1ffff, 18'h20000);
    drive_booth(18'h3ffff, 18'h3ffff);
    drive_booth(18'h1ffff, 18'h1ffff);
    for (int i = 0; i < n_booth_rand; i++) begin
      drive_booth(18'($random(seed)), 18'($random(seed)));
    end

    // raw sets go back to back so that several are in flight at once
    for (int i = 0; i < n_raw; i++) begin
      s = random_set(1'b0);
      drive_set(s, expected_product(s), $sformatf("random set %0d", i));
    end

    for (int i = 0; i < n_neg - 2; i++) begin
      s = random_set(1'b1);
      drive_set(s, expected_product(s), $sformatf("negative rows %0d", i));
    end
    s = '1;
    drive_set(s, expected_product(s), "all rows all ones");
    s = '0;
    for (int k = 0; k < mult18_pkg::pp_count; k++) begin
      s.pp[k] = 20'h80000;
    end
    drive_set(s, expected_product(s), "all rows most negative");

    stim_done = 1'b1;
  end

  initial begin : compare_results
    mult18_pkg::product_t exp;
    string                label;
    bit                   draining;
    wait (rstn === 1'b1);
    repeat (mult18_pipe_pkg::latency) begin
      @(posedge clk);
      check_reset(final_p, "output while the pipeline fills");
    end
    draining = 1'b1;
    while (draining) begin
      @(posedge clk);
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        label = label_q.pop_front();
        check_product(final_p, exp, label);
        checked++;
      end else if (stim_done) begin
        draining = 1'b0;
      end else begin
        other_errors++;
        $display("error at %0d ns: a result is due but no operand set was queued", $time);
      end
    end
    if (checked != total_vectors) begin
      other_errors++;
      $display("error: only %0d of %0d operand sets were checked", checked, total_vectors);
    end
    $display("errors: %0d mismatches, %0d other failures, %0d results checked",
             mismatch_errors, other_errors, checked);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+test
verilog/mult18_pkg.sv
verilog/mult18_pipe_pkg.sv
verilog/csa_row.sv
verilog/stage_reg.sv
verilog/wtree_reduce_upper.sv
verilog/wtree_reduce_mid.sv
verilog/wtree_resolve.sv
verilog/mult18_wtree.sv
test/tb_mult18_wtree.sv
